// File: verilog/fetch_pkg.sv
// fetch front end package: address, instruction and pc types, exception causes, opcodes
`default_nettype none

package fetch_pkg;

    // program counter, full xlen
    typedef logic [63:0] pc_t;

    // virtual address toward the icache
    // only the low 40 bits of the pc
    typedef logic [39:0] vaddr_t;

    // one 32-bit instruction word
    typedef logic [31:0] inst_t;

    // risc-v mcause encodings for fetch exceptions
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        INSTR_ACCESS_FAULT    = 4'd1,
        INSTR_PAGE_FAULT      = 4'd12
    } exc_cause_t;

    // next pc source
    // hold, sequential, or redirect
    typedef enum logic [1:0] {
        NEXT_PC_SEL_PC   = 2'd0,
        NEXT_PC_SEL_PC_4 = 2'd1,
        NEXT_PC_SEL_JUMP = 2'd2
    } next_pc_sel_t;

    // jal major opcode, inst[6:0]
    localparam logic [6:0] OPC_JAL = 7'b1101111;

endpackage

`default_nettype wire

// File: verilog/fetch_if.sv
// fetch entry link from the fetch stage to the fetch queue
`timescale 1ns/100ps
`default_nettype none

interface fetch_if;
    import fetch_pkg::*;

    // entry strobe, one entry per cycle when high
    logic       valid;
    // pc the entry was fetched from
    pc_t        pc;
    // instruction word, zero on misaligned entries
    inst_t      inst;
    // exception flag and its cause
    logic       ex_valid;
    exc_cause_t ex_cause;

    // fetch stage side
    modport source (output valid, output pc, output inst, output ex_valid, output ex_cause);

    // queue side
    modport sink (input valid, input pc, input inst, input ex_valid, input ex_cause);

endinterface

`default_nettype wire

// File: verilog/if_stage.sv
// fetch stage: holds the pc, picks the next pc, requests the icache and builds fetch entries
`timescale 1ns/100ps
`default_nettype none

module if_stage #(
    parameter fetch_pkg::pc_t RESET_PC = 64'h200
) (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    // queue full, no fetch this cycle
    input  logic                   stall_i,
    // next pc source and redirect target
    input  fetch_pkg::next_pc_sel_t next_pc_sel_i,
    input  fetch_pkg::pc_t         pc_jump_i,
    // icache response, same cycle as request
    input  logic                   icache_valid_i,
    input  fetch_pkg::inst_t       icache_data_i,
    input  logic                   icache_access_fault_i,
    input  logic                   icache_page_fault_i,
    // icache request
    output logic                   icache_req_valid_o,
    output fetch_pkg::vaddr_t      icache_vaddr_o,
    // entry toward the queue
    fetch_if.source                fetch_o
);
    import fetch_pkg::*;

    pc_t  pc_q;
    pc_t  next_pc;

    logic ex_misaligned;
    logic ex_access_fault;
    logic ex_page_fault;

    // next pc mux
    always_comb begin
        unique case (next_pc_sel_i)
            NEXT_PC_SEL_PC:   next_pc = pc_q;
            NEXT_PC_SEL_PC_4: next_pc = pc_q + 64'd4;
            NEXT_PC_SEL_JUMP: next_pc = pc_jump_i;
            default:          next_pc = pc_q;
        endcase
    end

    // pc register, loads every edge
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    // misalignment is caught here, before the cache
    assign ex_misaligned   = |pc_q[1:0];
    // faults only count on a valid response
    assign ex_access_fault = icache_valid_i & icache_access_fault_i;
    assign ex_page_fault   = icache_valid_i & icache_page_fault_i;

    // no request for a misaligned pc or a full queue
    assign icache_req_valid_o = !ex_misaligned && !stall_i;
    assign icache_vaddr_o     = pc_q[$bits(vaddr_t)-1:0];

    // entry from a cache response or a misaligned pc
    assign fetch_o.valid = !stall_i && (icache_valid_i || ex_misaligned);
    assign fetch_o.pc    = pc_q;
    // misaligned entries carry no instruction
    assign fetch_o.inst  = ex_misaligned ? '0 : icache_data_i;

    // exception priority
    // misaligned, then access fault, then page fault
    always_comb begin
        fetch_o.ex_valid = 1'b1;
        if (ex_misaligned) begin
            fetch_o.ex_cause = INSTR_ADDR_MISALIGNED;
        end else if (ex_access_fault) begin
            fetch_o.ex_cause = INSTR_ACCESS_FAULT;
        end else if (ex_page_fault) begin
            fetch_o.ex_cause = INSTR_PAGE_FAULT;
        end else begin
            fetch_o.ex_cause = INSTR_ADDR_MISALIGNED;
            fetch_o.ex_valid = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_queue.sv
// fetch queue: circular buffer of fetch entries between fetch and the branch unit
`timescale 1ns/100ps
`default_nettype none

module fetch_queue #(
    parameter int unsigned QDEPTH = 4
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    // entries from the fetch stage
    fetch_if.sink                push_i,
    input  logic                 pop_i,
    input  logic                 flush_i,
    output logic                 full_o,
    output logic                 empty_o,
    // head entry, read combinationally
    output fetch_pkg::pc_t       head_pc_o,
    output fetch_pkg::inst_t     head_inst_o,
    output logic                 head_ex_valid_o,
    output fetch_pkg::exc_cause_t head_ex_cause_o
);
    import fetch_pkg::*;

    localparam int unsigned AW = $clog2(QDEPTH);

    // entry storage, one array per field
    pc_t        mem_pc       [QDEPTH];
    inst_t      mem_inst     [QDEPTH];
    logic       mem_ex_valid [QDEPTH];
    exc_cause_t mem_ex_cause [QDEPTH];

    // pointers with an extra wrap bit
    logic [AW:0] wr_ptr_q;
    logic [AW:0] rd_ptr_q;
    logic        do_push;

    // flush drops a same cycle push
    assign do_push = push_i.valid && !flush_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // payload write
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_pc[wr_ptr_q[AW-1:0]]       <= push_i.pc;
            mem_inst[wr_ptr_q[AW-1:0]]     <= push_i.inst;
            mem_ex_valid[wr_ptr_q[AW-1:0]] <= push_i.ex_valid;
            mem_ex_cause[wr_ptr_q[AW-1:0]] <= push_i.ex_cause;
        end
    end

    // same index, different wrap bit means full
    assign empty_o = (wr_ptr_q == rd_ptr_q);
    assign full_o  = (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]) && (wr_ptr_q[AW] != rd_ptr_q[AW]);

    assign head_pc_o       = mem_pc[rd_ptr_q[AW-1:0]];
    assign head_inst_o     = mem_inst[rd_ptr_q[AW-1:0]];
    assign head_ex_valid_o = mem_ex_valid[rd_ptr_q[AW-1:0]];
    assign head_ex_cause_o = mem_ex_cause[rd_ptr_q[AW-1:0]];

endmodule

`default_nettype wire

// File: verilog/branch_unit.sv
// branch unit: drains the fetch queue to issue and redirects fetch on jal and exceptions
`timescale 1ns/100ps
`default_nettype none

module branch_unit #(
    parameter fetch_pkg::pc_t TRAP_VEC = 64'h100
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    // queue head
    input  logic                    empty_i,
    input  fetch_pkg::pc_t          head_pc_i,
    input  fetch_pkg::inst_t        head_inst_i,
    input  logic                    head_ex_valid_i,
    input  fetch_pkg::exc_cause_t   head_ex_cause_i,
    // fetch pushed an entry this cycle
    input  logic                    fetch_push_i,
    input  logic                    issue_stall_i,
    // queue control
    output logic                    pop_o,
    output logic                    flush_o,
    // fetch control
    output fetch_pkg::next_pc_sel_t next_pc_sel_o,
    output fetch_pkg::pc_t          pc_jump_o,
    // registered issue side
    output logic                    issue_valid_o,
    output fetch_pkg::pc_t          issue_pc_o,
    output fetch_pkg::inst_t        issue_inst_o,
    output logic                    issue_ex_valid_o,
    output fetch_pkg::exc_cause_t   issue_ex_cause_o
);
    import fetch_pkg::*;

    logic is_jal;
    logic redirect;
    pc_t  jal_imm;

    // drain whenever issue can take it
    assign pop_o = !empty_i && !issue_stall_i;

    // exception entries are never decoded
    assign is_jal = (head_inst_i[6:0] == OPC_JAL) && !head_ex_valid_i;

    // j-type immediate, sign extended
    assign jal_imm = {{43{head_inst_i[31]}}, head_inst_i[31], head_inst_i[19:12],
                      head_inst_i[20], head_inst_i[30:21], 1'b0};

    assign redirect = pop_o && (head_ex_valid_i || is_jal);
    assign flush_o  = redirect;

    // trap vector wins over the jump target
    assign pc_jump_o = head_ex_valid_i ? TRAP_VEC : head_pc_i + jal_imm;

    // redirect, then advance, then hold
    always_comb begin
        if (redirect) begin
            next_pc_sel_o = NEXT_PC_SEL_JUMP;
        end else if (fetch_push_i) begin
            next_pc_sel_o = NEXT_PC_SEL_PC_4;
        end else begin
            next_pc_sel_o = NEXT_PC_SEL_PC;
        end
    end

    // issue strobe
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= pop_o;
        end
    end

    // issue payload, captured on pop
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            issue_pc_o       <= head_pc_i;
            issue_inst_o     <= head_inst_i;
            issue_ex_valid_o <= head_ex_valid_i;
            issue_ex_cause_o <= head_ex_cause_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_top.sv
// fetch front end top: fetch stage, fetch queue and branch unit wired together
`timescale 1ns/100ps
`default_nettype none

module fetch_top #(
    parameter fetch_pkg::pc_t RESET_PC = 64'h200,
    parameter fetch_pkg::pc_t TRAP_VEC = 64'h100,
    parameter int unsigned    QDEPTH   = 4
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    // icache
    output logic                  icache_req_valid_o,
    output fetch_pkg::vaddr_t     icache_vaddr_o,
    input  logic                  icache_valid_i,
    input  fetch_pkg::inst_t      icache_data_i,
    input  logic                  icache_access_fault_i,
    input  logic                  icache_page_fault_i,
    // issue
    input  logic                  issue_stall_i,
    output logic                  issue_valid_o,
    output fetch_pkg::pc_t        issue_pc_o,
    output fetch_pkg::inst_t      issue_inst_o,
    output logic                  issue_ex_valid_o,
    output fetch_pkg::exc_cause_t issue_ex_cause_o
);
    import fetch_pkg::*;

    // fetch stage to queue
    fetch_if fetch_bus ();

    // queue status and head
    logic         q_full;
    logic         q_empty;
    pc_t          head_pc;
    inst_t        head_inst;
    logic         head_ex_valid;
    exc_cause_t   head_ex_cause;

    // branch unit control
    logic         q_pop;
    logic         q_flush;
    next_pc_sel_t next_pc_sel;
    pc_t          pc_jump;

    if_stage #(
        .RESET_PC (RESET_PC)
    ) i_if_stage (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .stall_i               (q_full),
        .next_pc_sel_i         (next_pc_sel),
        .pc_jump_i             (pc_jump),
        .icache_valid_i        (icache_valid_i),
        .icache_data_i         (icache_data_i),
        .icache_access_fault_i (icache_access_fault_i),
        .icache_page_fault_i   (icache_page_fault_i),
        .icache_req_valid_o    (icache_req_valid_o),
        .icache_vaddr_o        (icache_vaddr_o),
        .fetch_o               (fetch_bus.source)
    );

    fetch_queue #(
        .QDEPTH (QDEPTH)
    ) i_fetch_queue (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .push_i          (fetch_bus.sink),
        .pop_i           (q_pop),
        .flush_i         (q_flush),
        .full_o          (q_full),
        .empty_o         (q_empty),
        .head_pc_o       (head_pc),
        .head_inst_o     (head_inst),
        .head_ex_valid_o (head_ex_valid),
        .head_ex_cause_o (head_ex_cause)
    );

    branch_unit #(
        .TRAP_VEC (TRAP_VEC)
    ) i_branch_unit (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .empty_i          (q_empty),
        .head_pc_i        (head_pc),
        .head_inst_i      (head_inst),
        .head_ex_valid_i  (head_ex_valid),
        .head_ex_cause_i  (head_ex_cause),
        .fetch_push_i     (fetch_bus.valid),
        .issue_stall_i    (issue_stall_i),
        .pop_o            (q_pop),
        .flush_o          (q_flush),
        .next_pc_sel_o    (next_pc_sel),
        .pc_jump_o        (pc_jump),
        .issue_valid_o    (issue_valid_o),
        .issue_pc_o       (issue_pc_o),
        .issue_inst_o     (issue_inst_o),
        .issue_ex_valid_o (issue_ex_valid_o),
        .issue_ex_cause_o (issue_ex_cause_o)
    );

endmodule

`default_nettype wire

// File: bench/fetch_sva.sv
// fetch front end checks for queue overflow, icache request gating and issue after reset
`timescale 1ns/100ps
`default_nettype none

module fetch_sva #(
    parameter int unsigned QDEPTH = 4
) (
    input logic       clk_i,
    input logic       rstn_i,
    // fetch entry strobe into the queue
    input logic       push_i,
    // queue pop and flush from the branch unit
    input logic       pop_i,
    input logic       flush_i,
    input logic       req_valid_i,
    input logic [1:0] vaddr_lo_i,
    input logic       issue_valid_i
);

    localparam int unsigned OW = $clog2(QDEPTH) + 1;

    // entry count rebuilt from push, pop and flush
    logic [OW-1:0] occ_q;
    logic          model_full;

    // flush drops a same cycle push
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            occ_q <= '0;
        end else if (flush_i) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + OW'(push_i) - OW'(pop_i);
        end
    end

    assign model_full = (occ_q == OW'(QDEPTH));

    // a full queue must never take an entry
    a_no_push_when_full: assert property (
        @(posedge clk_i) disable iff (!rstn_i) model_full |-> !push_i
    ) else $error("fetch entry pushed while the queue is full");

    // stalled fetch sends nothing to the icache
    a_no_req_when_stalled: assert property (
        @(posedge clk_i) disable iff (!rstn_i) model_full |-> !req_valid_i
    ) else $error("icache request sent while fetch is stalled");

    // misaligned pc is trapped before the cache
    // and still turns into an entry when there is room
    a_no_req_misaligned: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
            (vaddr_lo_i != 2'b00) && !model_full |-> push_i && !req_valid_i
    ) else $error("misaligned address requested or not pushed as an entry");

    // first cycle out of reset issues nothing
    a_issue_idle_after_reset: assert property (
        @(posedge clk_i) $rose(rstn_i) |-> !issue_valid_i
    ) else $error("issue valid high right after reset");

endmodule

bind fetch_top fetch_sva #(
    .QDEPTH (QDEPTH)
) i_fetch_sva (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .push_i        (fetch_bus.valid),
    .pop_i         (q_pop),
    .flush_i       (q_flush),
    .req_valid_i   (icache_req_valid_o),
    .vaddr_lo_i    (icache_vaddr_o[1:0]),
    .issue_valid_i (issue_valid_o)
);

`default_nettype wire

// File: bench/fetch_tb.sv
// fetch front end testbench: icache model, test programs and a reference model of the issue stream
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam pc_t RESET_PC    = 64'h200;
    localparam pc_t TRAP_VEC    = 64'h100;
    localparam int  QDEPTH      = 4;
    // memory ends here, everything above is an access fault
    localparam pc_t MEM_LIMIT   = 64'h1000;
    localparam int  MEM_WORDS   = 1024;
    // one page of 256 bytes that page faults
    localparam pc_t FAULT_PAGE  = 64'h800;
    localparam pc_t PAGE_SIZE   = 64'h100;
    localparam int  MAX_BEATS   = 400;
    localparam logic [6:0] JAL_OP = 7'b1101111;

    logic       clk_i;
    logic       rstn_i;
    logic       icache_req_valid_o;
    vaddr_t     icache_vaddr_o;
    logic       icache_valid_i;
    inst_t      icache_data_i;
    logic       icache_access_fault_i;
    logic       icache_page_fault_i;
    logic       issue_stall_i;
    logic       issue_valid_o;
    pc_t        issue_pc_o;
    inst_t      issue_inst_o;
    logic       issue_ex_valid_o;
    exc_cause_t issue_ex_cause_o;

    inst_t      imem [0:MEM_WORDS-1];

    // expected issue stream
    pc_t        exp_pc    [0:MAX_BEATS-1];
    inst_t      exp_inst  [0:MAX_BEATS-1];
    logic       exp_exv   [0:MAX_BEATS-1];
    logic [3:0] exp_cause [0:MAX_BEATS-1];
    int         exp_cnt;
    int         beat_cnt;
    logic       mon_on;

    string      cur_test;
    int         seed = 32'he0ccd65b;
    int         err_cnt;
    int         test_err;
    int         n_tests;
    int         n_pass;

    fetch_top #(
        .RESET_PC (RESET_PC),
        .TRAP_VEC (TRAP_VEC),
        .QDEPTH   (QDEPTH)
    ) i_dut (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .icache_req_valid_o    (icache_req_valid_o),
        .icache_vaddr_o        (icache_vaddr_o),
        .icache_valid_i        (icache_valid_i),
        .icache_data_i         (icache_data_i),
        .icache_access_fault_i (icache_access_fault_i),
        .icache_page_fault_i   (icache_page_fault_i),
        .issue_stall_i         (issue_stall_i),
        .issue_valid_o         (issue_valid_o),
        .issue_pc_o            (issue_pc_o),
        .issue_inst_o          (issue_inst_o),
        .issue_ex_valid_o      (issue_ex_valid_o),
        .issue_ex_cause_o      (issue_ex_cause_o)
    );

    // 4 ns clock
    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // icache model, answers in the same cycle
    always_comb begin
        icache_valid_i        = icache_req_valid_o;
        icache_access_fault_i = 1'b0;
        icache_page_fault_i   = 1'b0;
        icache_data_i         = '0;
        if (64'(icache_vaddr_o) >= MEM_LIMIT) begin
            icache_access_fault_i = 1'b1;
        end else if (64'(icache_vaddr_o) >= FAULT_PAGE &&
                     64'(icache_vaddr_o) < FAULT_PAGE + PAGE_SIZE) begin
            icache_page_fault_i = 1'b1;
        end else begin
            icache_data_i = imem[icache_vaddr_o[11:2]];
        end
    end

    task automatic check_value(input string field, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        if (exp_v !== act_v) begin
            $display("Fail %s %s: expected %h actual %h", cur_test, field, exp_v, act_v);
            err_cnt++;
            test_err++;
        end
    endtask

    // j-type encoding, rd = x1
    function automatic inst_t encode_jal(input int imm);
        logic [20:0] im;
        im = imm[20:0];
        return {im[20], im[10:1], im[11], im[19:12], 5'd1, JAL_OP};
    endfunction

    // one step of the program: entry at pc, returns the pc that follows it
    function automatic pc_t ref_step(input pc_t pc, output inst_t inst, output logic exv,
                                     output logic [3:0] cause);
        logic [20:0] imm;
        pc_t         nxt;
        inst  = '0;
        exv   = 1'b1;
        cause = 4'd0;
        // misaligned beats access fault beats page fault
        if (pc[1:0] != 2'b00) begin
            cause = 4'd0;
        end else if (pc >= MEM_LIMIT) begin
            cause = 4'd1;
        end else if (pc >= FAULT_PAGE && pc < FAULT_PAGE + PAGE_SIZE) begin
            cause = 4'd12;
        end else begin
            exv  = 1'b0;
            inst = imem[pc[11:2]];
        end
        if (exv) begin
            nxt = TRAP_VEC;
        end else if (inst[6:0] == JAL_OP) begin
            imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            nxt = pc + {{43{imm[20]}}, imm};
        end else begin
            nxt = pc + 64'd4;
        end
        return nxt;
    endfunction

    task automatic build_expected(input int n);
        pc_t        pc;
        inst_t      inst;
        logic       exv;
        logic [3:0] cause;
        pc = RESET_PC;
        for (int k = 0; k < n; k++) begin
            exp_pc[k]    = pc;
            pc           = ref_step(pc, inst, exv, cause);
            exp_inst[k]  = inst;
            exp_exv[k]   = exv;
            exp_cause[k] = cause;
        end
        exp_cnt = n;
    endtask

    // plain alu ops only
    task automatic fill_plain();
        logic [31:0] r;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r       = $random(seed);
            imem[i] = {r[31:7], 7'h13};
        end
    endtask

    // about one jal in eight, offsets of +-1 KB, half of them misaligned
    task automatic fill_random();
        logic [31:0] r;
        logic [31:0] r2;
        for (int i = 0; i < MEM_WORDS; i++) begin
            r  = $random(seed);
            r2 = $random(seed);
            if (r[2:0] == 3'd0) begin
                imem[i] = encode_jal(int'({r2[10:1], 1'b0}) - 1024);
            end else begin
                imem[i] = {r[31:7], 7'h13};
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_i);
        #1;
        rstn_i        = 1'b0;
        issue_stall_i = 1'b0;
        repeat (4) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;
    endtask

    // compare every issue beat while a test runs
    always @(negedge clk_i) begin
        if (mon_on && issue_valid_o && beat_cnt < exp_cnt) begin
            check_value("pc", exp_pc[beat_cnt], issue_pc_o);
            check_value("inst", 64'(exp_inst[beat_cnt]), 64'(issue_inst_o));
            check_value("ex_valid", 64'(exp_exv[beat_cnt]), 64'(issue_ex_valid_o));
            if (exp_exv[beat_cnt]) begin
                check_value("ex_cause", 64'(exp_cause[beat_cnt]), 64'(issue_ex_cause_o));
            end
            beat_cnt = beat_cnt + 1;
        end
    end

    task automatic run_test(input string name, input int n, input logic stall_en);
        int          cycles;
        logic [31:0] r;
        cur_test = name;
        test_err = 0;
        beat_cnt = 0;
        build_expected(n);
        apply_reset();
        @(negedge clk_i);
        check_value("reset pc", 64'(RESET_PC[39:0]), 64'(icache_vaddr_o));
        check_value("reset issue_valid", 64'd0, 64'(issue_valid_o));
        mon_on = 1'b1;
        cycles = 0;
        while (beat_cnt < n && cycles < 50 + 20 * n) begin
            @(posedge clk_i);
            #1;
            r             = $random(seed);
            issue_stall_i = stall_en && (r[2:0] < 3'd5);
            cycles++;
        end
        mon_on        = 1'b0;
        issue_stall_i = 1'b0;
        if (beat_cnt < n) begin
            $display("timeout in test %s: only %0d of %0d instructions issued",
                     name, beat_cnt, n);
            err_cnt++;
            test_err++;
        end
        n_tests++;
        if (test_err == 0) begin
            n_pass++;
            $display("test %s: ok, %0d instructions", name, n);
        end else begin
            $display("test %s: %0d errors", name, test_err);
        end
    endtask

    initial begin
        rstn_i        = 1'b0;
        issue_stall_i = 1'b0;
        mon_on        = 1'b0;
        exp_cnt       = 0;
        beat_cnt      = 0;
        err_cnt       = 0;
        n_tests       = 0;
        n_pass        = 0;
        fill_plain();
        run_test("straight", 24, 1'b0);
        // forward jump then back to the start
        fill_plain();
        imem[32'h208 >> 2] = encode_jal(32'h100);
        imem[32'h310 >> 2] = encode_jal(-32'h110);
        run_test("jal", 24, 1'b0);
        // target 0x226 is misaligned
        fill_plain();
        imem[32'h204 >> 2] = encode_jal(32'h22);
        run_test("misaligned", 20, 1'b0);
        fill_plain();
        imem[32'h200 >> 2] = encode_jal(32'h1000);
        run_test("access_fault", 12, 1'b0);
        fill_plain();
        imem[32'h208 >> 2] = encode_jal(32'h600);
        run_test("page_fault", 12, 1'b0);
        fill_random();
        run_test("random_stall", 300, 1'b1);
        $display("tests: %0d run, %0d passed; errors: %0d", n_tests, n_pass, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
verilog/fetch_pkg.sv
verilog/fetch_if.sv
verilog/if_stage.sv
verilog/fetch_queue.sv
verilog/branch_unit.sv
verilog/fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module fetch_tb -o fetch_sim

out=$(./obj_dir/fetch_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1
